//--- dv/rv_core_cases.txt
# pc insn wb_we wb_rd wb_data illegal halt pc_relative gap_ok (all hex)
# pc_relative adds the idle-gap PC offset to wb_data; gap_ok allows NOP gaps before the line
00000000 00500093 1 01 00000005 0 0 0 0
00000004 ffd00113 1 02 fffffffd 0 0 0 1
00000008 002081b3 1 03 00000002 0 0 0 1
0000000c 40208233 1 04 00000008 0 0 0 1
00000010 001122b3 1 05 00000001 0 0 0 1
00000014 00113333 1 06 00000000 0 0 0 1
00000018 40115393 1 07 fffffffe 0 0 0 1
0000001c 00415413 1 08 0fffffff 0 0 0 1
00000020 00309493 1 09 00000028 0 0 0 1
00000024 0f014513 1 0a ffffff0d 0 0 0 1
00000028 1000e593 1 0b 00000105 0 0 0 1
0000002c 07f17613 1 0c 0000007d 0 0 0 1
00000030 ffe12693 1 0d 00000001 0 0 0 1
00000034 fff0b713 1 0e 00000001 0 0 0 1
00000038 123457b7 1 0f 12345000 0 0 0 1
0000003c 00001817 1 10 0000103c 0 0 1 1
00000040 401158b3 1 11 ffffffff 0 0 0 1
00000044 00109933 1 12 000000a0 0 0 0 1
00000048 001159b3 1 13 07ffffff 0 0 0 1
0000004c 0020ca33 1 14 fffffff8 0 0 0 1
00000050 0020eab3 1 15 fffffffd 0 0 0 1
00000054 0020fb33 1 16 00000005 0 0 0 1
00000058 00708013 0 00 00000000 0 0 0 1
0000005c 00000bb3 1 17 00000000 0 0 0 1
00000060 0000000f 0 00 00000000 0 0 0 1
00000064 0000ac03 0 00 00000000 1 0 0 1
00000068 00112023 0 00 00000000 1 0 0 1
0000006c 02108cb3 0 00 00000000 1 0 0 1
00000070 00108463 0 00 00000000 0 0 0 1
00000078 00109463 0 00 00000000 0 0 0 1
0000007c 00114463 0 00 00000000 0 0 0 1
00000084 00115463 0 00 00000000 0 0 0 1
00000088 00116463 0 00 00000000 0 0 0 1
0000008c 00117463 0 00 00000000 0 0 0 1
00000094 00208463 0 00 00000000 0 0 0 1
00000098 00209463 0 00 00000000 0 0 0 1
000000a0 0020c463 0 00 00000000 0 0 0 1
000000a4 0020d463 0 00 00000000 0 0 0 1
000000ac 0020e463 0 00 00000000 0 0 0 1
000000b4 0020f463 0 00 00000000 0 0 0 1
000000b8 01000d6f 1 1a 000000bc 0 0 1 1
000000c8 015d0de7 1 1b 000000cc 0 0 1 0
000000d0 001d8e13 1 1c 000000cd 0 0 1 0
000000d4 00000073 0 00 00000000 0 1 0 1
000000d4 00000073 0 00 00000000 0 1 0 0
000000d4 00000073 0 00 00000000 0 1 0 0

//--- filelist.f
+incdir+verilog
verilog/rv_pkg.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_pc_unit.sv
verilog/rv_core.sv
dv/tb_rv_core.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := tb_rv_core
FILELIST  := filelist.f

BIN     := obj_dir/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) verilog/rv_params.svh dv/rv_core_cases.txt

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

//--- dv/tb_rv_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_params.svh"

module tb_rv_core import rv_pkg::*; ();

  localparam word_t NOP_WORD = 32'h0000_0013;  // ADDI x0, x0, 0
  localparam int    RESET_CYCLES = 5;
  localparam int    MAX_GAP = 2;

  logic      clk;
  logic      rst;
  word_t     insn;
  word_t     pc;
  logic      wb_we;
  reg_addr_t wb_rd;
  word_t     wb_data;
  logic      halt;
  logic      illegal_insn;

  // Expected values with one entry per line of the case file
  word_t     exp_pc[$];
  word_t     case_insn[$];
  logic      exp_we[$];
  reg_addr_t exp_rd[$];
  word_t     exp_data[$];
  logic      exp_ill[$];
  logic      exp_halt[$];
  logic      pc_relative[$];  // wb_data shifts with the gap offset
  logic      gap_ok[$];
  logic      loaded;

  rv_core dut0 (
    .clk(clk), .rst(rst), .insn(insn), .pc(pc),
    .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data),
    .halt(halt), .illegal_insn(illegal_insn)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  task automatic check_reg_addr(input string what, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s is x%0d, expected x%0d", $time, what, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  task automatic read_cases();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f [9];
    fd = $fopen("dv/rv_core_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file dv/rv_core_cases.txt");
      $display("TESTBENCH FAILED");
      $fatal(1, "No case file");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.substr(0, 0) == "#") continue;  // Comment or blank
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                  f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
      if (n != 9) continue;
      exp_pc.push_back(f[0]);
      case_insn.push_back(f[1]);
      exp_we.push_back(f[2][0]);
      exp_rd.push_back(f[3][4:0]);
      exp_data.push_back(f[4]);
      exp_ill.push_back(f[5][0]);
      exp_halt.push_back(f[6][0]);
      pc_relative.push_back(f[7][0]);
      gap_ok.push_back(f[8][0]);
    end
    $fclose(fd);
    if (exp_pc.size() == 0) begin
      $display("The case file dv/rv_core_cases.txt holds no usable cases");
      $display("TESTBENCH FAILED");
      $fatal(1, "No cases");
    end
  endtask

  // Idle NOP that must write nothing and still step the PC
  task automatic idle_cycle(input word_t pc_exp);
    check_word("pc during gap", pc, pc_exp);
    insn = NOP_WORD;
    #7;
    check_bit("wb_we during gap", wb_we, 1'b0);
    check_bit("illegal_insn during gap", illegal_insn, 1'b0);
    check_bit("halt during gap", halt, 1'b0);
    @(posedge clk);
    #1;
  endtask

  initial begin
    word_t offset;
    int    gaps;
    rst    = 1'b1;
    insn   = NOP_WORD;
    loaded = 1'b0;
    offset = '0;
    void'($urandom(32'h8d1bc08f));
    read_cases();
    loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int i = 0; i < exp_pc.size(); i++) begin
      gaps = gap_ok[i] ? int'($urandom % (MAX_GAP + 1)) : 0;
      repeat (gaps) begin
        idle_cycle(exp_pc[i] + offset);
        offset = offset + word_t'(`RV_INSN_BYTES);
      end
      check_word("pc", pc, exp_pc[i] + offset);
      insn = case_insn[i];
      #7;  // Commit outputs settle well before the next edge
      check_bit("wb_we", wb_we, exp_we[i]);
      check_bit("illegal_insn", illegal_insn, exp_ill[i]);
      check_bit("halt", halt, exp_halt[i]);
      if (exp_we[i]) begin
        check_reg_addr("wb_rd", wb_rd, exp_rd[i]);
        check_word("wb_data", wb_data, pc_relative[i] ? exp_data[i] + offset : exp_data[i]);
      end
      @(posedge clk);
      #1;
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

  // Watchdog sized from the case count
  initial begin
    longint limit;
    wait (loaded);
    limit = 10 * (2 * exp_pc.size() + RESET_CYCLES + MAX_GAP * exp_pc.size() + 10);
    #(limit);
    $display("The run timed out after %0d ns without finishing the cases", limit);
    $display("TESTBENCH FAILED");
    $fatal(1, "Timeout");
  end

endmodule

`default_nettype wire

//--- verilog/rv_core.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  word_t     insn,
  output word_t     pc,
  output logic      wb_we,
  output reg_addr_t wb_rd,
  output word_t     wb_data,
  output logic      halt,
  output logic      illegal_insn
);

  reg_addr_t  rs1, rs2, rd;
  word_t      imm;
  alu_op_t    alu_op;
  alu_src_a_t alu_src_a;
  alu_src_b_t alu_src_b;
  wb_src_t    wb_src;
  pc_src_t    pc_src;
  logic [2:0] branch_funct;
  logic       reg_we;
  word_t      rs1_data, rs2_data;
  word_t      alu_a, alu_b, alu_result;
  word_t      link_addr;

  rv_decoder u_decoder (
    .insn(insn), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
    .alu_op(alu_op), .alu_src_a(alu_src_a), .alu_src_b(alu_src_b),
    .wb_src(wb_src), .pc_src(pc_src), .branch_funct(branch_funct),
    .reg_we(reg_we), .halt(halt), .illegal_insn(illegal_insn)
  );

  rv_regfile u_regfile (
    .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd),
    .wr_data(wb_data), .we(reg_we),
    .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  // Operand selects, PC only for AUIPC
  assign alu_a = (alu_src_a == SRC_A_PC)  ? pc  : rs1_data;
  assign alu_b = (alu_src_b == SRC_B_IMM) ? imm : rs2_data;

  rv_alu u_alu (
    .a(alu_a), .b(alu_b), .alu_op(alu_op), .result(alu_result)
  );

  rv_pc_unit u_pc_unit (
    .clk(clk), .rst(rst), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .imm(imm), .pc_src(pc_src), .branch_funct(branch_funct),
    .halt(halt), .pc(pc), .link_addr(link_addr)
  );

  // Commit record, written back at the next edge
  assign wb_data = (wb_src == WB_LINK) ? link_addr : alu_result;
  assign wb_we   = reg_we;
  assign wb_rd   = rd;

endmodule

`default_nettype wire

//--- verilog/rv_pc_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_params.svh"

module rv_pc_unit import rv_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  word_t      rs1_data,
  input  word_t      rs2_data,
  input  word_t      imm,
  input  pc_src_t    pc_src,
  input  logic [2:0] branch_funct,
  input  logic       halt,
  output word_t      pc,
  output word_t      link_addr
);

  word_t pc_next;
  word_t pc_seq;
  word_t pc_rel;   // Target of taken branches and JAL
  word_t jalr_sum;
  logic  taken;

  assign pc_seq    = pc + word_t'(`RV_INSN_BYTES);
  assign pc_rel    = pc + imm;
  assign jalr_sum  = rs1_data + imm;
  assign link_addr = pc_seq;

  // Branch condition from funct3
  always_comb begin
    case (branch_funct)
      3'b000:  taken = (rs1_data == rs2_data);
      3'b001:  taken = (rs1_data != rs2_data);
      3'b100:  taken = ($signed(rs1_data) < $signed(rs2_data));
      3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      3'b110:  taken = (rs1_data < rs2_data);
      3'b111:  taken = (rs1_data >= rs2_data);
      default: taken = 1'b0;  // Reserved, decoder flags these
    endcase
  end

  always_comb begin
    if (halt) begin
      pc_next = pc;  // Stay on the ECALL
    end else begin
      case (pc_src)
        PC_BRANCH: pc_next = taken ? pc_rel : pc_seq;
        PC_JAL:    pc_next = pc_rel;
        PC_JALR:   pc_next = {jalr_sum[`RV_XLEN-1:1], 1'b0};
        default:   pc_next = pc_seq;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= word_t'(`RV_RESET_PC);
    end else begin
      pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

//--- verilog/rv_alu.sv
`timescale 1ns/1ns
`default_nettype none

module rv_alu import rv_pkg::*; (
  input  word_t   a,
  input  word_t   b,
  input  alu_op_t alu_op,
  output word_t   result
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt = b[4:0];  // Only the low five bits count for RV32

  assign lt_signed   = ($signed(a) < $signed(b));
  assign lt_unsigned = (a < b);

  always_comb begin
    case (alu_op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_SLL:    result = a << shamt;
      ALU_SLT:    result = {31'd0, lt_signed};
      ALU_SLTU:   result = {31'd0, lt_unsigned};
      ALU_XOR:    result = a ^ b;
      ALU_SRL:    result = a >> shamt;
      ALU_SRA:    result = $signed(a) >>> shamt;  // Sign fills from the left
      ALU_OR:     result = a | b;
      ALU_AND:    result = a & b;
      ALU_PASS_B: result = b;
      default:    result = a + b;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/rv_regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_params.svh"

module rv_regfile import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  reg_addr_t rd,
  input  word_t     wr_data,
  input  logic      we,
  output word_t     rs1_data,
  output word_t     rs2_data
);

  word_t regs [`RV_NUM_REGS];

  for (genvar i = 0; i < `RV_NUM_REGS; i++) begin : g_reg
    if (i == 0) begin : g_zero
      assign regs[i] = '0;  // x0 reads zero forever
    end else begin : g_cell
      word_t q;

      always_ff @(posedge clk) begin
        if (rst) begin
          q <= '0;
        end else if (we && rd == reg_addr_t'(i)) begin
          q <= wr_data;
        end
      end

      assign regs[i] = q;
    end
  end

  // Asynchronous reads
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

endmodule

`default_nettype wire

//--- verilog/rv_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module rv_decoder import rv_pkg::*; (
  input  word_t      insn,
  output reg_addr_t  rs1,
  output reg_addr_t  rs2,
  output reg_addr_t  rd,
  output word_t      imm,
  output alu_op_t    alu_op,
  output alu_src_a_t alu_src_a,
  output alu_src_b_t alu_src_b,
  output wb_src_t    wb_src,
  output pc_src_t    pc_src,
  output logic [2:0] branch_funct,
  output logic       reg_we,
  output logic       halt,
  output logic       illegal_insn
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;
  pc_src_t    pc_sel;  // Before the illegal override
  logic       wr_req;
  logic       ecall;

  assign opcode = opcode_t'(insn[6:0]);
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign funct7 = insn[31:25];

  assign branch_funct = funct3;

  // Sign-extended immediates per format
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  // ECALL is the one SYSTEM encoding with every other field zero
  assign ecall = (insn[31:7] == 25'd0);

  always_comb begin
    imm          = imm_i;
    alu_op       = ALU_ADD;
    alu_src_a    = SRC_A_RS1;
    alu_src_b    = SRC_B_IMM;
    wb_src       = WB_ALU;
    pc_sel       = PC_SEQ;
    wr_req       = 1'b0;
    halt         = 1'b0;
    illegal_insn = 1'b0;

    case (opcode)
      OPC_LUI: begin
        imm    = imm_u;
        alu_op = ALU_PASS_B;
        wr_req = 1'b1;
      end
      OPC_AUIPC: begin
        imm       = imm_u;
        alu_src_a = SRC_A_PC;
        wr_req    = 1'b1;
      end
      OPC_JAL: begin
        imm    = imm_j;
        pc_sel = PC_JAL;
        wb_src = WB_LINK;
        wr_req = 1'b1;
      end
      OPC_JALR: begin
        pc_sel       = PC_JALR;
        wb_src       = WB_LINK;
        wr_req       = 1'b1;
        illegal_insn = (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        imm          = imm_b;
        pc_sel       = PC_BRANCH;
        illegal_insn = (funct3 == 3'b010) || (funct3 == 3'b011);  // Reserved
      end
      OPC_OP_IMM: begin
        wr_req = 1'b1;
        case (funct3)
          3'b000: alu_op = ALU_ADD;
          3'b010: alu_op = ALU_SLT;
          3'b011: alu_op = ALU_SLTU;
          3'b100: alu_op = ALU_XOR;
          3'b110: alu_op = ALU_OR;
          3'b111: alu_op = ALU_AND;
          3'b001: begin
            alu_op       = ALU_SLL;
            illegal_insn = (funct7 != 7'b0000000);
          end
          default: begin  // 3'b101, SRLI or SRAI
            alu_op       = funct7[5] ? ALU_SRA : ALU_SRL;
            illegal_insn = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
          end
        endcase
      end
      OPC_OP: begin
        alu_src_b = SRC_B_RS2;
        wr_req    = 1'b1;
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000:  alu_op = ALU_ADD;
            3'b001:  alu_op = ALU_SLL;
            3'b010:  alu_op = ALU_SLT;
            3'b011:  alu_op = ALU_SLTU;
            3'b100:  alu_op = ALU_XOR;
            3'b101:  alu_op = ALU_SRL;
            3'b110:  alu_op = ALU_OR;
            default: alu_op = ALU_AND;
          endcase
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          alu_op = ALU_SUB;
        end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
          alu_op = ALU_SRA;
        end else begin
          illegal_insn = 1'b1;  // Includes the M extension
        end
      end
      OPC_MISC_MEM: illegal_insn = (funct3 != 3'b000);  // FENCE is a no-op
      OPC_SYSTEM: begin
        halt         = ecall;
        illegal_insn = !ecall;
      end
      OPC_LOAD, OPC_STORE: illegal_insn = 1'b1;  // No data memory
      default: illegal_insn = 1'b1;
    endcase
  end

  // Illegal words fall through sequentially and write nothing
  assign pc_src = illegal_insn ? PC_SEQ : pc_sel;
  assign reg_we = wr_req && !illegal_insn && (rd != '0);

endmodule

`default_nettype wire

//--- verilog/rv_pkg.sv
`default_nettype none

`include "rv_params.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

  // Major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    OPC_LOAD     = 7'b00_000_11,  // Decoded only to flag as illegal
    OPC_STORE    = 7'b01_000_11,  // Same
    OPC_BRANCH   = 7'b11_000_11,
    OPC_JALR     = 7'b11_001_11,
    OPC_MISC_MEM = 7'b00_011_11,
    OPC_JAL      = 7'b11_011_11,
    OPC_OP_IMM   = 7'b00_100_11,
    OPC_OP       = 7'b01_100_11,
    OPC_SYSTEM   = 7'b11_100_11,
    OPC_AUIPC    = 7'b00_101_11,
    OPC_LUI      = 7'b01_101_11
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
    ALU_PASS_B  // LUI result is the immediate itself
  } alu_op_t;

  typedef enum logic {SRC_A_RS1, SRC_A_PC} alu_src_a_t;
  typedef enum logic {SRC_B_RS2, SRC_B_IMM} alu_src_b_t;

  typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JAL, PC_JALR} pc_src_t;

  // Writeback from ALU or from the link address PC + 4
  typedef enum logic {WB_ALU, WB_LINK} wb_src_t;

endpackage

`default_nettype wire

//--- verilog/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Data and address word width
`define RV_XLEN 32

// Architectural register file
`define RV_NUM_REGS 32
`define RV_REG_ADDR_W 5

// First fetch address after reset
`define RV_RESET_PC 0

// Sequential PC step, one 32-bit instruction
`define RV_INSN_BYTES 4

`endif
